// File: decodePkg.sv
`default_nettype none

package decodePkg;

    // Field widths
    localparam int InstrWidth   = 32;
    localparam int OpWidth      = 6;
    localparam int RegAddrWidth = 5;
    localparam int ImmWidth     = 16;
    localparam int AluOpWidth   = 5;

    // One instruction word, read as R-format or I-format fields
    typedef union packed {
        struct packed {
            logic [OpWidth-1:0]      opcode;
            logic [RegAddrWidth-1:0] rs;
            logic [RegAddrWidth-1:0] rt;
            logic [RegAddrWidth-1:0] rd;
            logic [RegAddrWidth-1:0] shamt;
            logic [OpWidth-1:0]      funct;
        } rFormat;
        struct packed {
            logic [OpWidth-1:0]      opcode;
            logic [RegAddrWidth-1:0] rs;
            logic [RegAddrWidth-1:0] rt;
            logic [ImmWidth-1:0]     imm;
        } iFormat;
    } instrWord_u;

    // Primary opcodes
    localparam logic [OpWidth-1:0] OpTypeR  = 6'h00;
    localparam logic [OpWidth-1:0] OpRegimm = 6'h01;
    localparam logic [OpWidth-1:0] OpJ      = 6'h02;
    localparam logic [OpWidth-1:0] OpJal    = 6'h03;
    localparam logic [OpWidth-1:0] OpBeq    = 6'h04;
    localparam logic [OpWidth-1:0] OpBne    = 6'h05;
    localparam logic [OpWidth-1:0] OpBlez   = 6'h06;
    localparam logic [OpWidth-1:0] OpBgtz   = 6'h07;
    localparam logic [OpWidth-1:0] OpAddi   = 6'h08;
    localparam logic [OpWidth-1:0] OpAddiu  = 6'h09;
    localparam logic [OpWidth-1:0] OpSlti   = 6'h0a;
    localparam logic [OpWidth-1:0] OpSltiu  = 6'h0b;
    localparam logic [OpWidth-1:0] OpAndi   = 6'h0c;
    localparam logic [OpWidth-1:0] OpOri    = 6'h0d;
    localparam logic [OpWidth-1:0] OpXori   = 6'h0e;
    localparam logic [OpWidth-1:0] OpLui    = 6'h0f;
    localparam logic [OpWidth-1:0] OpLb     = 6'h20;
    localparam logic [OpWidth-1:0] OpLh     = 6'h21;
    localparam logic [OpWidth-1:0] OpLw     = 6'h23;
    localparam logic [OpWidth-1:0] OpLbu    = 6'h24;
    localparam logic [OpWidth-1:0] OpLhu    = 6'h25;
    localparam logic [OpWidth-1:0] OpSb     = 6'h28;
    localparam logic [OpWidth-1:0] OpSh     = 6'h29;
    localparam logic [OpWidth-1:0] OpSw     = 6'h2b;

    // R-type function codes
    localparam logic [OpWidth-1:0] FunctSll  = 6'h00;
    localparam logic [OpWidth-1:0] FunctSrl  = 6'h02;
    localparam logic [OpWidth-1:0] FunctSra  = 6'h03;
    localparam logic [OpWidth-1:0] FunctJr   = 6'h08;
    localparam logic [OpWidth-1:0] FunctJalr = 6'h09;
    localparam logic [OpWidth-1:0] FunctAdd  = 6'h20;
    localparam logic [OpWidth-1:0] FunctAddu = 6'h21;
    localparam logic [OpWidth-1:0] FunctSub  = 6'h22;
    localparam logic [OpWidth-1:0] FunctSubu = 6'h23;
    localparam logic [OpWidth-1:0] FunctAnd  = 6'h24;
    localparam logic [OpWidth-1:0] FunctOr   = 6'h25;
    localparam logic [OpWidth-1:0] FunctXor  = 6'h26;
    localparam logic [OpWidth-1:0] FunctNor  = 6'h27;
    localparam logic [OpWidth-1:0] FunctSlt  = 6'h2a;
    localparam logic [OpWidth-1:0] FunctSltu = 6'h2b;

    // Regimm rt field
    localparam logic [RegAddrWidth-1:0] RtBltz = 5'h00;
    localparam logic [RegAddrWidth-1:0] RtBgez = 5'h01;

    // ALU operations
    localparam logic [AluOpWidth-1:0] AluAdd  = 5'd0;
    localparam logic [AluOpWidth-1:0] AluAddu = 5'd1;
    localparam logic [AluOpWidth-1:0] AluSub  = 5'd2;
    localparam logic [AluOpWidth-1:0] AluSubu = 5'd3;
    localparam logic [AluOpWidth-1:0] AluAnd  = 5'd4;
    localparam logic [AluOpWidth-1:0] AluOr   = 5'd5;
    localparam logic [AluOpWidth-1:0] AluXor  = 5'd6;
    localparam logic [AluOpWidth-1:0] AluNor  = 5'd7;
    localparam logic [AluOpWidth-1:0] AluSlt  = 5'd8;
    localparam logic [AluOpWidth-1:0] AluSltu = 5'd9;
    localparam logic [AluOpWidth-1:0] AluSll  = 5'd10;
    localparam logic [AluOpWidth-1:0] AluSrl  = 5'd11;
    localparam logic [AluOpWidth-1:0] AluSra  = 5'd12;
    // Shift immediate left by 16, for lui
    localparam logic [AluOpWidth-1:0] AluSllc = 5'd13;

    // Next-PC source
    localparam logic [1:0] PcSeq     = 2'd0;
    localparam logic [1:0] PcJumpReg = 2'd1;
    localparam logic [1:0] PcBranch  = 2'd2;
    localparam logic [1:0] PcJumpImm = 2'd3;

endpackage

`default_nettype wire

// File: ctrlIf.sv
`timescale 1ns/1ps
`default_nettype none

interface ctrlIf;
    // Datapath controls
    logic regWrite;
    logic memToReg;
    logic memRead;
    logic memWrite;
    logic memByte;
    logic memHalf;
    logic memSignExtend;
    logic aluSrcImm;
    logic regDst;
    logic link;
    logic signExtend;
    // Control-flow class
    logic branch;
    logic jumpImm;
    logic jumpReg;
    logic reserved;
    logic [decodePkg::AluOpWidth-1:0] aluOp;

    modport decode (
        output regWrite, memToReg, memRead, memWrite, memByte, memHalf, memSignExtend,
        output aluSrcImm, regDst, link, signExtend, branch, jumpImm, jumpReg, reserved
    );
    modport alu (output aluOp);
    modport resolve (input branch, jumpImm, jumpReg);
    modport stage (
        input regWrite, memToReg, memRead, memWrite, memByte, memHalf, memSignExtend,
        input aluSrcImm, regDst, link, signExtend, branch, jumpImm, jumpReg, reserved,
        input aluOp
    );
endinterface

`default_nettype wire

// File: opcodeDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module opcodeDecoder (
    input  decodePkg::instrWord_u instr,
    ctrlIf.decode                 ctrl
);

    logic [decodePkg::OpWidth-1:0] opcode;
    logic unknown;

    assign opcode = instr.iFormat.opcode;

    always_comb begin
        ctrl.regWrite      = 1'b0;
        ctrl.memToReg      = 1'b0;
        ctrl.memRead       = 1'b0;
        ctrl.memWrite      = 1'b0;
        ctrl.memByte       = 1'b0;
        ctrl.memHalf       = 1'b0;
        ctrl.memSignExtend = 1'b0;
        ctrl.aluSrcImm     = 1'b0;
        ctrl.regDst        = 1'b0;
        ctrl.link          = 1'b0;
        ctrl.branch        = 1'b0;
        ctrl.jumpImm       = 1'b0;
        ctrl.jumpReg       = 1'b0;
        unknown            = 1'b0;

        case (opcode)
            decodePkg::OpTypeR: begin
                case (instr.rFormat.funct)
                    decodePkg::FunctJr: begin
                        ctrl.jumpReg = 1'b1;
                    end
                    // Return address goes to rd
                    decodePkg::FunctJalr: begin
                        ctrl.jumpReg  = 1'b1;
                        ctrl.link     = 1'b1;
                        ctrl.regWrite = 1'b1;
                        ctrl.regDst   = 1'b1;
                    end
                    decodePkg::FunctSll, decodePkg::FunctSrl, decodePkg::FunctSra,
                    decodePkg::FunctAdd, decodePkg::FunctAddu, decodePkg::FunctSub,
                    decodePkg::FunctSubu, decodePkg::FunctAnd, decodePkg::FunctOr,
                    decodePkg::FunctXor, decodePkg::FunctNor, decodePkg::FunctSlt,
                    decodePkg::FunctSltu: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.regDst   = 1'b1;
                    end
                    default: unknown = 1'b1;
                endcase
            end
            // Only bltz and bgez are kept from the regimm group
            decodePkg::OpRegimm: begin
                if (instr.iFormat.rt == decodePkg::RtBltz ||
                    instr.iFormat.rt == decodePkg::RtBgez) begin
                    ctrl.branch = 1'b1;
                end else begin
                    unknown = 1'b1;
                end
            end
            decodePkg::OpBeq, decodePkg::OpBne, decodePkg::OpBlez, decodePkg::OpBgtz: begin
                ctrl.branch = 1'b1;
            end
            decodePkg::OpJ: begin
                ctrl.jumpImm = 1'b1;
            end
            // Link register r31 selected downstream by link
            decodePkg::OpJal: begin
                ctrl.jumpImm  = 1'b1;
                ctrl.link     = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            decodePkg::OpAddi, decodePkg::OpAddiu, decodePkg::OpSlti, decodePkg::OpSltiu,
            decodePkg::OpAndi, decodePkg::OpOri, decodePkg::OpXori, decodePkg::OpLui: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            decodePkg::OpLb, decodePkg::OpLh, decodePkg::OpLw, decodePkg::OpLbu,
            decodePkg::OpLhu: begin
                ctrl.regWrite      = 1'b1;
                ctrl.memRead       = 1'b1;
                ctrl.memToReg      = 1'b1;
                ctrl.aluSrcImm     = 1'b1;
                ctrl.memByte       = (opcode == decodePkg::OpLb) || (opcode == decodePkg::OpLbu);
                ctrl.memHalf       = (opcode == decodePkg::OpLh) || (opcode == decodePkg::OpLhu);
                ctrl.memSignExtend = (opcode == decodePkg::OpLb) || (opcode == decodePkg::OpLh);
            end
            decodePkg::OpSb, decodePkg::OpSh, decodePkg::OpSw: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.memByte   = (opcode == decodePkg::OpSb);
                ctrl.memHalf   = (opcode == decodePkg::OpSh);
            end
            default: unknown = 1'b1;
        endcase

        // Logical immediates and lui take a zero-extended immediate
        ctrl.signExtend = !unknown && !(opcode inside {decodePkg::OpAndi, decodePkg::OpOri,
                                                        decodePkg::OpXori, decodePkg::OpLui});
        ctrl.reserved   = unknown;
    end

endmodule

`default_nettype wire

// File: aluOpDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module aluOpDecoder (
    input  decodePkg::instrWord_u instr,
    ctrlIf.alu                    ctrl
);

    always_comb begin
        // Addu for everything that only needs an address or nothing at all
        ctrl.aluOp = decodePkg::AluAddu;
        case (instr.iFormat.opcode)
            decodePkg::OpTypeR: begin
                case (instr.rFormat.funct)
                    decodePkg::FunctSll:  ctrl.aluOp = decodePkg::AluSll;
                    decodePkg::FunctSrl:  ctrl.aluOp = decodePkg::AluSrl;
                    decodePkg::FunctSra:  ctrl.aluOp = decodePkg::AluSra;
                    decodePkg::FunctAdd:  ctrl.aluOp = decodePkg::AluAdd;
                    decodePkg::FunctAddu: ctrl.aluOp = decodePkg::AluAddu;
                    decodePkg::FunctSub:  ctrl.aluOp = decodePkg::AluSub;
                    decodePkg::FunctSubu: ctrl.aluOp = decodePkg::AluSubu;
                    decodePkg::FunctAnd:  ctrl.aluOp = decodePkg::AluAnd;
                    decodePkg::FunctOr:   ctrl.aluOp = decodePkg::AluOr;
                    decodePkg::FunctXor:  ctrl.aluOp = decodePkg::AluXor;
                    decodePkg::FunctNor:  ctrl.aluOp = decodePkg::AluNor;
                    decodePkg::FunctSlt:  ctrl.aluOp = decodePkg::AluSlt;
                    decodePkg::FunctSltu: ctrl.aluOp = decodePkg::AluSltu;
                    // jr, jalr and unknown funct codes
                    default:              ctrl.aluOp = decodePkg::AluAddu;
                endcase
            end
            decodePkg::OpAddi:  ctrl.aluOp = decodePkg::AluAdd;
            decodePkg::OpAddiu: ctrl.aluOp = decodePkg::AluAddu;
            decodePkg::OpSlti:  ctrl.aluOp = decodePkg::AluSlt;
            decodePkg::OpSltiu: ctrl.aluOp = decodePkg::AluSltu;
            decodePkg::OpAndi:  ctrl.aluOp = decodePkg::AluAnd;
            decodePkg::OpOri:   ctrl.aluOp = decodePkg::AluOr;
            decodePkg::OpXori:  ctrl.aluOp = decodePkg::AluXor;
            decodePkg::OpLui:   ctrl.aluOp = decodePkg::AluSllc;
            default:            ctrl.aluOp = decodePkg::AluAddu;
        endcase
    end

endmodule

`default_nettype wire

// File: branchResolver.sv
`timescale 1ns/1ps
`default_nettype none

module branchResolver (
    input  decodePkg::instrWord_u instr,
    input  logic                  cmpEq,
    input  logic                  cmpGz,
    input  logic                  cmpGez,
    input  logic                  cmpLz,
    input  logic                  cmpLez,
    ctrlIf.resolve                ctrl,
    output logic [1:0]            pcSrc,
    output logic                  nextIsDelay
);

    logic taken;

    // Condition per branch opcode, regimm picks by rt bit 0
    always_comb begin
        case (instr.iFormat.opcode)
            decodePkg::OpBeq:  taken = cmpEq;
            decodePkg::OpBne:  taken = !cmpEq;
            decodePkg::OpBgtz: taken = cmpGz;
            decodePkg::OpBlez: taken = cmpLez;
            default:           taken = instr.iFormat.rt[0] ? cmpGez : cmpLz;
        endcase
    end

    always_comb begin
        if (ctrl.jumpReg) begin
            pcSrc = decodePkg::PcJumpReg;
        end else if (ctrl.jumpImm) begin
            pcSrc = decodePkg::PcJumpImm;
        end else if (ctrl.branch && taken) begin
            pcSrc = decodePkg::PcBranch;
        end else begin
            pcSrc = decodePkg::PcSeq;
        end
    end

    // Delay slot always executes, taken or not
    assign nextIsDelay = ctrl.branch || ctrl.jumpImm || ctrl.jumpReg;

endmodule

`default_nettype wire

// File: controlPipeReg.sv
`timescale 1ns/1ps
`default_nettype none

module controlPipeReg (
    input  logic                             clock,
    input  logic                             rstN,
    input  logic                             instrValid,
    input  logic                             stall,
    ctrlIf.stage                             ctrl,
    input  logic [1:0]                       pcSrcIn,
    input  logic                             nextIsDelayIn,
    output logic                             ctrlValid,
    output logic                             regWrite,
    output logic                             memToReg,
    output logic                             memRead,
    output logic                             memWrite,
    output logic                             memByte,
    output logic                             memHalf,
    output logic                             memSignExtend,
    output logic                             aluSrcImm,
    output logic                             regDst,
    output logic                             link,
    output logic                             signExtend,
    output logic                             reservedInstr,
    output logic                             nextIsDelay,
    output logic [decodePkg::AluOpWidth-1:0] aluOp,
    output logic [1:0]                       pcSrc
);

    logic        accept;
    logic [13:0] flagsQ;

    assign accept = instrValid && !stall;

    // Bubble is all flags low, Addu and sequential PC
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            flagsQ <= '0;
            aluOp  <= decodePkg::AluAddu;
            pcSrc  <= decodePkg::PcSeq;
        end else if (accept) begin
            flagsQ <= {1'b1, ctrl.regWrite, ctrl.memToReg, ctrl.memRead, ctrl.memWrite,
                       ctrl.memByte, ctrl.memHalf, ctrl.memSignExtend, ctrl.aluSrcImm,
                       ctrl.regDst, ctrl.link, ctrl.signExtend, ctrl.reserved, nextIsDelayIn};
            aluOp  <= ctrl.aluOp;
            pcSrc  <= pcSrcIn;
        end else begin
            flagsQ <= '0;
            aluOp  <= decodePkg::AluAddu;
            pcSrc  <= decodePkg::PcSeq;
        end
    end

    assign {ctrlValid, regWrite, memToReg, memRead, memWrite, memByte, memHalf, memSignExtend,
            aluSrcImm, regDst, link, signExtend, reservedInstr, nextIsDelay} = flagsQ;

    // Decoder encodings as seen after the stage register
    memExclusive: assert property (@(posedge clock) disable iff (!rstN)
        !(memRead && memWrite));

    reservedQuiet: assert property (@(posedge clock) disable iff (!rstN)
        reservedInstr |-> !regWrite && !memRead && !memWrite);

    linkWrites: assert property (@(posedge clock) disable iff (!rstN)
        link |-> regWrite);

endmodule

`default_nettype wire

// File: mipsDecodeTop.sv
`timescale 1ns/1ps
`default_nettype none

module mipsDecodeTop (
    input  logic                             clock,
    input  logic                             rstN,
    input  logic                             instrValid,
    input  logic                             stall,
    input  logic [decodePkg::InstrWidth-1:0] instr,
    input  logic                             cmpEq,
    input  logic                             cmpGz,
    input  logic                             cmpGez,
    input  logic                             cmpLz,
    input  logic                             cmpLez,
    output logic                             ctrlValid,
    output logic                             regWrite,
    output logic                             memToReg,
    output logic                             memRead,
    output logic                             memWrite,
    output logic                             memByte,
    output logic                             memHalf,
    output logic                             memSignExtend,
    output logic                             aluSrcImm,
    output logic                             regDst,
    output logic                             link,
    output logic                             signExtend,
    output logic                             reservedInstr,
    output logic                             nextIsDelay,
    output logic [decodePkg::AluOpWidth-1:0] aluOp,
    output logic [1:0]                       pcSrc
);

    decodePkg::instrWord_u instrWord;
    logic [1:0]            pcSrcD;
    logic                  nextIsDelayD;

    assign instrWord = decodePkg::instrWord_u'(instr);

    ctrlIf ctrl ();

    opcodeDecoder i_opcodeDecoder (
        .instr (instrWord),
        .ctrl  (ctrl.decode)
    );

    aluOpDecoder i_aluOpDecoder (
        .instr (instrWord),
        .ctrl  (ctrl.alu)
    );

    branchResolver i_branchResolver (
        .instr       (instrWord),
        .cmpEq       (cmpEq),
        .cmpGz       (cmpGz),
        .cmpGez      (cmpGez),
        .cmpLz       (cmpLz),
        .cmpLez      (cmpLez),
        .ctrl        (ctrl.resolve),
        .pcSrc       (pcSrcD),
        .nextIsDelay (nextIsDelayD)
    );

    // ID/EX boundary
    controlPipeReg i_controlPipeReg (
        .clock         (clock),
        .rstN          (rstN),
        .instrValid    (instrValid),
        .stall         (stall),
        .ctrl          (ctrl.stage),
        .pcSrcIn       (pcSrcD),
        .nextIsDelayIn (nextIsDelayD),
        .ctrlValid     (ctrlValid),
        .regWrite      (regWrite),
        .memToReg      (memToReg),
        .memRead       (memRead),
        .memWrite      (memWrite),
        .memByte       (memByte),
        .memHalf       (memHalf),
        .memSignExtend (memSignExtend),
        .aluSrcImm     (aluSrcImm),
        .regDst        (regDst),
        .link          (link),
        .signExtend    (signExtend),
        .reservedInstr (reservedInstr),
        .nextIsDelay   (nextIsDelay),
        .aluOp         (aluOp),
        .pcSrc         (pcSrc)
    );

endmodule

`default_nettype wire

// File: tbDecodeModel.svh
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

// Expected ID/EX outputs for one cycle
typedef struct packed {
    logic       ctrlValid;
    logic       regWrite;
    logic       memToReg;
    logic       memRead;
    logic       memWrite;
    logic       memByte;
    logic       memHalf;
    logic       memSignExtend;
    logic       aluSrcImm;
    logic       regDst;
    logic       link;
    logic       signExtend;
    logic       reservedInstr;
    logic       nextIsDelay;
    logic [4:0] aluOp;
    logic [1:0] pcSrc;
} ctrlExp_t;

// Idle stage, also the reset value
function automatic ctrlExp_t bubbleCtrl();
    ctrlExp_t e;
    e = '0;
    e.aluOp = decodePkg::AluAddu;
    e.pcSrc = decodePkg::PcSeq;
    return e;
endfunction

function automatic ctrlExp_t modelDecode(input logic [31:0] w, input logic eq,
                                         input logic gz, input logic gez,
                                         input logic lz, input logic lez);
    ctrlExp_t   e;
    logic [5:0] op;
    logic [5:0] fn;
    logic       bad;
    e = bubbleCtrl();
    op = w[31:26];
    fn = w[5:0];
    bad = 1'b0;
    e.ctrlValid = 1'b1;
    e.signExtend = 1'b1;
    case (op)
        decodePkg::OpTypeR: begin
            e.regWrite = 1'b1;
            e.regDst = 1'b1;
            case (fn)
                decodePkg::FunctSll:  e.aluOp = decodePkg::AluSll;
                decodePkg::FunctSrl:  e.aluOp = decodePkg::AluSrl;
                decodePkg::FunctSra:  e.aluOp = decodePkg::AluSra;
                decodePkg::FunctAdd:  e.aluOp = decodePkg::AluAdd;
                decodePkg::FunctAddu: e.aluOp = decodePkg::AluAddu;
                decodePkg::FunctSub:  e.aluOp = decodePkg::AluSub;
                decodePkg::FunctSubu: e.aluOp = decodePkg::AluSubu;
                decodePkg::FunctAnd:  e.aluOp = decodePkg::AluAnd;
                decodePkg::FunctOr:   e.aluOp = decodePkg::AluOr;
                decodePkg::FunctXor:  e.aluOp = decodePkg::AluXor;
                decodePkg::FunctNor:  e.aluOp = decodePkg::AluNor;
                decodePkg::FunctSlt:  e.aluOp = decodePkg::AluSlt;
                decodePkg::FunctSltu: e.aluOp = decodePkg::AluSltu;
                decodePkg::FunctJr: begin
                    e.regWrite = 1'b0;
                    e.regDst = 1'b0;
                    e.pcSrc = decodePkg::PcJumpReg;
                end
                decodePkg::FunctJalr: begin
                    e.link = 1'b1;
                    e.pcSrc = decodePkg::PcJumpReg;
                end
                default: bad = 1'b1;
            endcase
        end
        decodePkg::OpBeq:  e.pcSrc = eq ? decodePkg::PcBranch : decodePkg::PcSeq;
        decodePkg::OpBne:  e.pcSrc = eq ? decodePkg::PcSeq : decodePkg::PcBranch;
        decodePkg::OpBgtz: e.pcSrc = gz ? decodePkg::PcBranch : decodePkg::PcSeq;
        decodePkg::OpBlez: e.pcSrc = lez ? decodePkg::PcBranch : decodePkg::PcSeq;
        decodePkg::OpRegimm: begin
            if (w[20:16] == decodePkg::RtBltz) begin
                e.pcSrc = lz ? decodePkg::PcBranch : decodePkg::PcSeq;
            end else if (w[20:16] == decodePkg::RtBgez) begin
                e.pcSrc = gez ? decodePkg::PcBranch : decodePkg::PcSeq;
            end else begin
                bad = 1'b1;
            end
        end
        decodePkg::OpJ: e.pcSrc = decodePkg::PcJumpImm;
        decodePkg::OpJal: begin
            e.pcSrc = decodePkg::PcJumpImm;
            e.link = 1'b1;
            e.regWrite = 1'b1;
        end
        decodePkg::OpAddi:  e.aluOp = decodePkg::AluAdd;
        decodePkg::OpAddiu: e.aluOp = decodePkg::AluAddu;
        decodePkg::OpSlti:  e.aluOp = decodePkg::AluSlt;
        decodePkg::OpSltiu: e.aluOp = decodePkg::AluSltu;
        decodePkg::OpAndi:  e.aluOp = decodePkg::AluAnd;
        decodePkg::OpOri:   e.aluOp = decodePkg::AluOr;
        decodePkg::OpXori:  e.aluOp = decodePkg::AluXor;
        decodePkg::OpLui:   e.aluOp = decodePkg::AluSllc;
        decodePkg::OpLb, decodePkg::OpLh, decodePkg::OpLw, decodePkg::OpLbu,
        decodePkg::OpLhu, decodePkg::OpSb, decodePkg::OpSh, decodePkg::OpSw: begin
            // Size in op[1:0], unsigned loads have op[2], stores op[3]
            e.aluSrcImm = 1'b1;
            e.memByte = (op[1:0] == 2'b00);
            e.memHalf = (op[1:0] == 2'b01);
            e.memWrite = op[3];
            e.memRead = !op[3];
            e.memToReg = !op[3];
            e.regWrite = !op[3];
            // Only lb and lh are signed, lw has no unsigned twin
            e.memSignExtend = !op[3] && !op[2] && !op[1];
        end
        default: bad = 1'b1;
    endcase
    // Opcodes 0x08 to 0x0f with zero extension from 0x0c up
    if (op[5:3] == 3'b001) begin
        e.regWrite = 1'b1;
        e.aluSrcImm = 1'b1;
        e.signExtend = (op[5:2] != 4'b0011);
    end
    // Opcodes 0x01 to 0x07 are all branches and jumps
    e.nextIsDelay = (e.pcSrc != decodePkg::PcSeq) ||
                    (op[5:3] == 3'b000 && op != decodePkg::OpTypeR);
    if (bad) begin
        e = bubbleCtrl();
        e.ctrlValid = 1'b1;
        e.reservedInstr = 1'b1;
    end
    return e;
endfunction

`endif

// File: tbMipsDecode.sv
`timescale 1ns/1ps
`default_nettype none

module tbMipsDecode;

    `include "tbDecodeModel.svh"

    localparam int NumTests    = 6;
    localparam int TestCycles  = 2000;
    localparam int ResetCycles = 10;
    // Whole run plus a quarter for margin
    localparam int CycleLimit  = NumTests * TestCycles * 5 / 4;
    localparam logic [31:0] Seed = 32'h5709_dc50;

    localparam logic [5:0] AluFuncts [13] = '{
        decodePkg::FunctSll, decodePkg::FunctSrl, decodePkg::FunctSra, decodePkg::FunctAdd,
        decodePkg::FunctAddu, decodePkg::FunctSub, decodePkg::FunctSubu, decodePkg::FunctAnd,
        decodePkg::FunctOr, decodePkg::FunctXor, decodePkg::FunctNor, decodePkg::FunctSlt,
        decodePkg::FunctSltu
    };
    localparam logic [5:0] MemOps [8] = '{
        decodePkg::OpLb, decodePkg::OpLh, decodePkg::OpLw, decodePkg::OpLbu,
        decodePkg::OpLhu, decodePkg::OpSb, decodePkg::OpSh, decodePkg::OpSw
    };
    localparam logic [5:0] BranchOps [5] = '{
        decodePkg::OpBeq, decodePkg::OpBne, decodePkg::OpBlez, decodePkg::OpBgtz,
        decodePkg::OpRegimm
    };

    logic        clock = 1'b0;
    logic        rstN;
    logic        instrValid;
    logic        stall;
    logic [31:0] instr;
    logic        cmpEq;
    logic        cmpGz;
    logic        cmpGez;
    logic        cmpLz;
    logic        cmpLez;
    logic        ctrlValid;
    logic        regWrite;
    logic        memToReg;
    logic        memRead;
    logic        memWrite;
    logic        memByte;
    logic        memHalf;
    logic        memSignExtend;
    logic        aluSrcImm;
    logic        regDst;
    logic        link;
    logic        signExtend;
    logic        reservedInstr;
    logic        nextIsDelay;
    logic [4:0]  aluOp;
    logic [1:0]  pcSrc;

    ctrlExp_t expQ [$];
    int       errors = 0;
    int       checks = 0;
    int       cycleCount = 0;
    string    testNames [NumTests] = '{"reset and mixed", "ALU", "loads and stores",
                                       "branches", "jumps", "stalls and reserved words"};

    mipsDecodeTop i_mipsDecodeTop (.*);

    initial begin
        forever #4 clock = ~clock;
    end

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
    end

    task automatic checkField(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // Class 1 ALU, 2 memory, 3 branch, 4 jump, others mix all four
    function automatic logic [31:0] keptWord(input int cls);
        logic [31:0] w;
        int          c;
        int          idx;
        w = $urandom;
        c = cls;
        if (cls == 0 || cls == 5) begin
            c = int'($urandom_range(4, 1));
        end
        case (c)
            1: begin
                if ($urandom_range(1) == 1) begin
                    idx = $urandom_range(12);
                    w[31:26] = decodePkg::OpTypeR;
                    w[5:0] = AluFuncts[idx];
                end else begin
                    w[31:26] = {3'b001, 3'($urandom_range(7))};
                end
            end
            2: begin
                idx = $urandom_range(7);
                w[31:26] = MemOps[idx];
            end
            3: begin
                idx = $urandom_range(4);
                w[31:26] = BranchOps[idx];
                // Keeps regimm rt at bltz or bgez
                w[20:17] = 4'b0000;
            end
            default: begin
                idx = $urandom_range(3);
                if (idx < 2) begin
                    w[31:26] = idx[0] ? decodePkg::OpJal : decodePkg::OpJ;
                end else begin
                    w[31:26] = decodePkg::OpTypeR;
                    w[5:0] = idx[0] ? decodePkg::FunctJalr : decodePkg::FunctJr;
                end
            end
        endcase
        return w;
    endfunction

    // Record what the DUT samples at this edge, then drive the next inputs
    task automatic runCycle(input int t);
        logic accept;
        logic useKept;
        @(posedge clock);
        accept = rstN && instrValid && !stall;
        if (accept) begin
            expQ.push_back(modelDecode(instr, cmpEq, cmpGz, cmpGez, cmpLz, cmpLez));
        end else begin
            expQ.push_back(bubbleCtrl());
        end
        useKept = (t == 5) ? ($urandom_range(1) == 0) : ($urandom_range(4) != 0);
        instr <= useKept ? keptWord(t) : $urandom;
        instrValid <= ($urandom_range(9) != 0);
        stall <= (t == 5) ? ($urandom_range(2) == 0) : ($urandom_range(9) == 0);
        {cmpEq, cmpGz, cmpGez, cmpLz, cmpLez} <= 5'($urandom);
    endtask

    // Outputs settle after the rising edge
    always @(negedge clock) begin
        ctrlExp_t e;
        if (expQ.size() == 0) begin
            errors++;
            $display("Scoreboard error at %0t: no expected value was queued", $time);
        end else begin
            e = expQ.pop_front();
            checkField("ctrlValid", 32'(ctrlValid), 32'(e.ctrlValid));
            checkField("regWrite", 32'(regWrite), 32'(e.regWrite));
            checkField("memToReg", 32'(memToReg), 32'(e.memToReg));
            checkField("memRead", 32'(memRead), 32'(e.memRead));
            checkField("memWrite", 32'(memWrite), 32'(e.memWrite));
            checkField("memByte", 32'(memByte), 32'(e.memByte));
            checkField("memHalf", 32'(memHalf), 32'(e.memHalf));
            checkField("memSignExtend", 32'(memSignExtend), 32'(e.memSignExtend));
            checkField("aluSrcImm", 32'(aluSrcImm), 32'(e.aluSrcImm));
            checkField("regDst", 32'(regDst), 32'(e.regDst));
            checkField("link", 32'(link), 32'(e.link));
            checkField("signExtend", 32'(signExtend), 32'(e.signExtend));
            checkField("reservedInstr", 32'(reservedInstr), 32'(e.reservedInstr));
            checkField("nextIsDelay", 32'(nextIsDelay), 32'(e.nextIsDelay));
            checkField("aluOp", 32'(aluOp), 32'(e.aluOp));
            checkField("pcSrc", 32'(pcSrc), 32'(e.pcSrc));
        end
    end

    initial begin
        int errorsBefore;
        void'($urandom(Seed));
        rstN = 1'b0;
        instrValid = 1'b0;
        stall = 1'b0;
        instr = '0;
        {cmpEq, cmpGz, cmpGez, cmpLz, cmpLez} = '0;
        for (int t = 0; t < NumTests; t++) begin
            errorsBefore = errors;
            if (t == 0) begin
                repeat (ResetCycles) runCycle(t);
                rstN <= 1'b1;
            end
            repeat (TestCycles) runCycle(t);
            $display("Test %0d %s finished with %0d errors", t + 1, testNames[t],
                     errors - errorsBefore);
        end
        // Last queued value is checked on this falling edge
        @(negedge clock);
        #1;
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        wait (cycleCount >= CycleLimit);
        $display("Timeout: the run did not end within %0d clock cycles", CycleLimit);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
decodePkg.sv
ctrlIf.sv
opcodeDecoder.sv
aluOpDecoder.sv
branchResolver.sv
controlPipeReg.sv
mipsDecodeTop.sv
tbMipsDecode.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the decoder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module tbMipsDecode -o simv
output="$(./obj_dir/simv)"
echo "$output"

if ! grep -qx "All tests passed" <<< "$output"; then
    exit 1
fi
